// File: filelist.f
rtl/wb_pkg.sv
rtl/writeback_stage.sv
rtl/arch_regfile.sv
rtl/store_queue.sv
rtl/store_drain.sv
rtl/writeback_top.sv
testbench/wb_mem_model.sv
testbench/tb_writeback_top.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -sv --top-module tb_writeback_top \
    -f filelist.f --Mdir obj_dir -o sim_tb

status=0
./obj_dir/sim_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    exit 1
fi
exit "$status"

// File: testbench/tb_writeback_top.sv
`timescale 1ns/1ps

module tb_writeback_top import wb_pkg::*; ();

    localparam int LIMIT = 200;  // cycles per wait

    typedef struct packed {
        addr_t      adr;
        logic [7:0] sel;
        wb_data_t   dat;
    } bus_write_t;

    logic       clk;
    logic       rst_n;
    logic       valid_in;
    wb_instr_t  instr;
    reg_idx_t   rd_idx;
    logic       wb_ack;
    logic       stall;
    addr_t      new_eip;
    logic       is_resteer;
    gpr_data_t  gpr_rd_data;
    seg_data_t  seg_rd_data;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    addr_t      wb_adr;
    wb_data_t   wb_dat_w;
    logic [7:0] wb_sel;
    logic [2:0] ack_delay;
    logic       slow_ack;
    logic       log_valid;
    addr_t      log_adr;
    logic [7:0] log_sel;
    wb_data_t   log_dat;

    logic [31:0] rng;
    logic [31:0] delay_rng;
    gpr_data_t   model_gpr [8];
    seg_data_t   model_seg [8];
    bus_write_t  exp_q [$];
    logic        resteer_pend;
    int          errors;
    int          stalls_seen;
    int          writes_seen;

    writeback_top #(.QUEUE_DEPTH(2)) i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .valid_in    (valid_in),
        .instr       (instr),
        .rd_idx      (rd_idx),
        .wb_ack      (wb_ack),
        .stall       (stall),
        .new_eip     (new_eip),
        .is_resteer  (is_resteer),
        .gpr_rd_data (gpr_rd_data),
        .seg_rd_data (seg_rd_data),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .wb_sel      (wb_sel)
    );

    wb_mem_model i_mem (
        .clk       (clk),
        .rst_n     (rst_n),
        .cyc       (wb_cyc),
        .stb       (wb_stb),
        .we        (wb_we),
        .adr       (wb_adr),
        .dat_w     (wb_dat_w),
        .sel       (wb_sel),
        .ack_delay (ack_delay),
        .ack       (wb_ack),
        .log_valid (log_valid),
        .log_adr   (log_adr),
        .log_sel   (log_sel),
        .log_dat   (log_dat)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rand32();
        rng = xorshift(rng);
        return rng;
    endfunction

    // expected bus write for a store from size and lane rules
    function automatic bus_write_t expected_write(input wb_instr_t ins, input int s);
        bus_write_t w;
        int         size;
        int         off;
        size = int'(ins.op_size);
        for (int b = 0; b < 4; b++) begin
            if (ins.size_ovr[b]) begin
                size = b;
            end
        end
        if (ins.ld_eip_cs) begin
            size = 3;
        end
        off = int'(ins.slot[s].dest[2:0]);
        w.adr = {ins.slot[s].dest[31:3], 3'b000};
        w.sel = 8'(((1 << (1 << size)) - 1) << off);
        w.dat = ins.slot[s].data << (8 * off);
        return w;
    endfunction

    function automatic wb_instr_t random_instr();
        wb_instr_t   ins;
        logic [31:0] r;
        ins = '0;
        for (int s = 0; s < NUM_SLOTS; s++) begin
            r = rand32();
            ins.slot[s].data   = {rand32(), rand32()};
            ins.slot[s].dest   = rand32();
            ins.slot[s].is_reg = r[0];
            ins.slot[s].is_seg = r[1];
            ins.slot[s].wb_en  = r[2] | r[3];
        end
        r = rand32();
        // slots 1 and 3 collide on one index
        ins.slot[1].dest[2:0] = ins.slot[3].dest[2:0];
        ins.slot[1].is_reg    = 1'b1;
        ins.slot[3].is_reg    = 1'b1;
        ins.slot[1].wb_en     = 1'b1;
        ins.slot[3].wb_en     = 1'b1;
        ins.slot[1].is_seg    = r[4];
        ins.slot[3].is_seg    = r[4];
        ins.op_size    = r[6:5];
        ins.ld_eip_cs  = r[7];
        ins.br_valid   = r[8];
        ins.br_taken   = r[9];
        ins.br_correct = r[10];
        ins.eip        = rand32();
        ins.br_fip     = rand32();
        return ins;
    endfunction

    // mode 0 op_size, mode 1 size override, mode 2 far jump
    function automatic wb_instr_t store_instr(input int size, input int mode);
        wb_instr_t   ins;
        int          eff;
        int          nbytes;
        int          ms;
        int          off;
        logic [31:0] r;
        ins    = random_instr();
        r      = rand32();
        eff    = (mode == 2) ? 3 : size;
        nbytes = 1 << eff;
        ms     = int'(r[1:0]);
        off    = int'(r[4:2]) % (8 / nbytes) * nbytes;  // aligned to its size
        ins.op_size   = (mode == 1) ? op_size_t'(eff + 1) : op_size_t'(size);
        ins.size_ovr  = (mode == 1) ? size_ovr_t'(1 << eff) : '0;
        ins.ld_eip_cs = (mode == 2);
        r = rand32();
        ins.slot[ms].dest   = {r[31:3], 3'(off)};
        ins.slot[ms].is_mem = 1'b1;
        ins.slot[ms].wb_en  = 1'b1;
        ins.slot[ms].is_reg = 1'b0;
        ins.slot[ms].is_seg = 1'b0;
        if (ms > 0) begin
            ins.slot[ms-1].is_mem = 1'b1;  // disabled slot must be skipped
            ins.slot[ms-1].wb_en  = 1'b0;
        end
        return ins;
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("[ERROR] %s: got %h expected %h", name, got, exp);
        errors++;
    endtask

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s", what);
        errors++;
    endtask

    // called at posedge+1 and returns at posedge+1 after retirement
    task automatic issue(input wb_instr_t ins);
        int    waited;
        int    ms;
        addr_t exp_eip;
        ms = -1;
        for (int s = NUM_SLOTS - 1; s >= 0; s--) begin
            if (ins.slot[s].is_mem && ins.slot[s].wb_en) begin
                ms = s;
            end
        end
        valid_in = 1'b1;
        instr    = ins;
        #1;
        if (stall && ms < 0) begin
            $display("stall raised for an instruction without a store");
            errors++;
        end
        waited = 0;
        while (stall && waited < LIMIT) begin
            stalls_seen++;
            waited++;
            @(posedge clk);
            #2;
        end
        if (stall) begin
            report_timeout("stall to clear");
        end
        exp_eip = ins.br_taken ? (ins.ld_eip_cs ? ins.slot[0].data[31:0] : ins.br_fip)
                               : ins.eip;
        if (new_eip !== exp_eip) begin
            report_mismatch("new_eip", 64'(new_eip), 64'(exp_eip));
        end
        if (ms >= 0) begin
            exp_q.push_back(expected_write(ins, ms));
        end
        for (int s = 0; s < NUM_SLOTS; s++) begin
            if (ins.slot[s].wb_en && ins.slot[s].is_reg) begin
                model_gpr[ins.slot[s].dest[2:0]] = ins.slot[s].data[31:0];
            end
            if (ins.slot[s].wb_en && ins.slot[s].is_seg) begin
                model_seg[ins.slot[s].dest[2:0]] = ins.slot[s].data[15:0];
            end
        end
        resteer_pend = ins.br_valid && !ins.br_correct;
        @(posedge clk);
        #1;
        valid_in = 1'b0;
    endtask

    task automatic check_regs();
        for (int r = 0; r < 8; r++) begin
            rd_idx = reg_idx_t'(r);
            #1;
            if (gpr_rd_data !== model_gpr[r]) begin
                report_mismatch($sformatf("gpr_rd_data[%0d]", r), 64'(gpr_rd_data),
                                64'(model_gpr[r]));
            end
            if (seg_rd_data !== model_seg[r]) begin
                report_mismatch($sformatf("seg_rd_data[%0d]", r), 64'(seg_rd_data),
                                64'(model_seg[r]));
            end
            @(posedge clk);
            #1;
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < LIMIT) begin
            waited++;
            @(posedge clk);
            #1;
        end
        if (exp_q.size() != 0) begin
            report_timeout("stores to reach memory");
        end
    endtask

    // ack delay for the memory model is redrawn every cycle
    initial begin
        forever begin
            @(posedge clk);
            #1;
            delay_rng = xorshift(delay_rng);
            ack_delay = slow_ack ? 3'd5 : 3'(delay_rng % 6);
        end
    end

    initial begin
        logic exp_rs;
        forever begin
            @(posedge clk);
            exp_rs       = resteer_pend;
            resteer_pend = 1'b0;
            #3;
            if (is_resteer !== exp_rs) begin
                report_mismatch("is_resteer", 64'(is_resteer), 64'(exp_rs));
            end
        end
    end

    // logged writes checked against expected stores in order
    initial begin
        bus_write_t w;
        forever begin
            @(posedge clk);
            #3;
            if (log_valid) begin
                if (exp_q.size() == 0) begin
                    $display("bus write to %h with no store outstanding", log_adr);
                    errors++;
                end else begin
                    w = exp_q.pop_front();
                    writes_seen++;
                    if (log_adr !== w.adr) begin
                        report_mismatch("wb_adr", 64'(log_adr), 64'(w.adr));
                    end
                    if (log_sel !== w.sel) begin
                        report_mismatch("wb_sel", 64'(log_sel), 64'(w.sel));
                    end
                    if (log_dat !== w.dat) begin
                        report_mismatch("wb_dat_w", log_dat, w.dat);
                    end
                end
            end
        end
    end

    initial begin
        wb_instr_t ins;
        rst_n        = 1'b0;
        valid_in     = 1'b0;
        instr        = '0;
        rd_idx       = '0;
        ack_delay    = '0;
        slow_ack     = 1'b0;
        rng          = 32'hbe9e;
        delay_rng    = 32'hbe9e;
        resteer_pend = 1'b0;
        errors       = 0;
        stalls_seen  = 0;
        writes_seen  = 0;
        for (int r = 0; r < 8; r++) begin
            model_gpr[r] = '0;
            model_seg[r] = '0;
        end
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;

        if (stall !== 1'b0) report_mismatch("stall", 64'(stall), 64'(0));
        if (is_resteer !== 1'b0) report_mismatch("is_resteer", 64'(is_resteer), 64'(0));
        if (wb_cyc !== 1'b0) report_mismatch("wb_cyc", 64'(wb_cyc), 64'(0));
        if (wb_stb !== 1'b0) report_mismatch("wb_stb", 64'(wb_stb), 64'(0));
        check_regs();

        for (int i = 0; i < 40; i++) begin
            issue(random_instr());
            if (i % 8 == 7) begin
                check_regs();
            end
        end

        for (int n = 0; n < 2; n++) begin
            for (int size = 0; size < 4; size++) begin
                for (int mode = 0; mode < 3; mode++) begin
                    issue(store_instr(size, mode));
                end
            end
        end
        wait_drain();
        check_regs();

        // slow slave fills the queue
        slow_ack    = 1'b1;
        stalls_seen = 0;
        for (int i = 0; i < 15; i++) begin
            if (i % 3 == 2) begin
                issue(random_instr());
            end else begin
                issue(store_instr(int'(rand32() % 4), int'(rand32() % 3)));
            end
        end
        wait_drain();
        if (stalls_seen == 0) begin
            $display("stall never rose while stores met a full queue");
            errors++;
        end
        slow_ack = 1'b0;
        check_regs();

        for (int i = 0; i < 16; i++) begin
            ins            = random_instr();
            ins.br_valid   = 1'b1;
            ins.br_taken   = i[0];
            ins.br_correct = i[1];
            ins.ld_eip_cs  = i[2];
            issue(ins);
        end
        repeat (4) @(posedge clk);
        #1;
        check_regs();
        wait_drain();

        $display("errors: %0d, bus writes checked: %0d", errors, writes_seen);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: testbench/wb_mem_model.sv
`timescale 1ns/1ps

module wb_mem_model import wb_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       cyc,
    input  logic       stb,
    input  logic       we,
    input  addr_t      adr,
    input  wb_data_t   dat_w,
    input  logic [7:0] sel,
    input  logic [2:0] ack_delay,  // sampled when a cycle starts
    output logic       ack,
    output logic       log_valid,
    output addr_t      log_adr,
    output logic [7:0] log_sel,
    output wb_data_t   log_dat
);

    logic       busy;
    logic [2:0] wait_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack       <= 1'b0;
            busy      <= 1'b0;
            wait_cnt  <= '0;
            log_valid <= 1'b0;
            log_adr   <= '0;
            log_sel   <= '0;
            log_dat   <= '0;
        end else begin
            log_valid <= 1'b0;
            if (ack) begin
                ack  <= 1'b0;  // single-cycle ack
                busy <= 1'b0;
            end else if (cyc && stb) begin
                if (!busy) begin
                    busy     <= 1'b1;
                    wait_cnt <= ack_delay;
                    ack      <= (ack_delay == 3'd0);
                end else begin
                    wait_cnt <= wait_cnt - 1'b1;
                    ack      <= (wait_cnt <= 3'd1);
                end
            end
            // transfer completes on an edge with ack and stb both high
            if (ack && cyc && stb && we) begin
                log_valid <= 1'b1;
                log_adr   <= adr;
                log_sel   <= sel;
                log_dat   <= dat_w;
            end
        end
    end

endmodule

// File: rtl/writeback_top.sv
`timescale 1ns/1ps

module writeback_top import wb_pkg::*; #(
    parameter int QUEUE_DEPTH = 2
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       valid_in,
    input  wb_instr_t  instr,
    input  reg_idx_t   rd_idx,
    input  logic       wb_ack,
    output logic       stall,
    output addr_t      new_eip,
    output logic       is_resteer,
    output gpr_data_t  gpr_rd_data,
    output seg_data_t  seg_rd_data,
    output logic       wb_cyc,
    output logic       wb_stb,
    output logic       wb_we,
    output addr_t      wb_adr,
    output wb_data_t   wb_dat_w,
    output logic [7:0] wb_sel
);

    reg_write_t [NUM_SLOTS-1:0] gpr_wr;
    reg_write_t [NUM_SLOTS-1:0] seg_wr;
    logic                       push;
    store_req_t                 push_req;
    logic                       queue_full;
    logic                       queue_empty;
    store_req_t                 queue_head;
    logic                       pop;

    writeback_stage i_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .valid_in   (valid_in),
        .instr      (instr),
        .queue_full (queue_full),
        .stall      (stall),
        .gpr_wr     (gpr_wr),
        .seg_wr     (seg_wr),
        .push       (push),
        .push_req   (push_req),
        .new_eip    (new_eip),
        .is_resteer (is_resteer)
    );

    arch_regfile i_regfile (
        .clk         (clk),
        .rst_n       (rst_n),
        .gpr_wr      (gpr_wr),
        .seg_wr      (seg_wr),
        .rd_idx      (rd_idx),
        .gpr_rd_data (gpr_rd_data),
        .seg_rd_data (seg_rd_data)
    );

    store_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) i_queue (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (push),
        .push_req (push_req),
        .pop      (pop),
        .head     (queue_head),
        .full     (queue_full),
        .empty    (queue_empty)
    );

    store_drain i_drain (
        .clk      (clk),
        .rst_n    (rst_n),
        .head     (queue_head),
        .empty    (queue_empty),
        .wb_ack   (wb_ack),
        .pop      (pop),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_sel   (wb_sel)
    );

endmodule

// File: rtl/store_drain.sv
`timescale 1ns/1ps

module store_drain import wb_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  store_req_t head,
    input  logic       empty,
    input  logic       wb_ack,
    output logic       pop,
    output logic       wb_cyc,
    output logic       wb_stb,
    output logic       wb_we,
    output addr_t      wb_adr,
    output wb_data_t   wb_dat_w,
    output logic [7:0] wb_sel
);

    drain_state_t state;
    store_req_t   req_q;
    logic [2:0]   lane_off;
    logic [7:0]   size_mask;

    assign pop = (state == DRAIN_IDLE) & ~empty;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= DRAIN_IDLE;
        end else begin
            case (state)
                DRAIN_IDLE: if (!empty) state <= DRAIN_BUS;
                DRAIN_BUS:  if (wb_ack) state <= DRAIN_IDLE;  // idle one cycle between stores
                default:    state <= DRAIN_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            req_q <= head;
        end
    end

    always_comb begin
        case (req_q.size)
            2'd0:    size_mask = 8'h01;
            2'd1:    size_mask = 8'h03;
            2'd2:    size_mask = 8'h0f;
            default: size_mask = 8'hff;
        endcase
    end

    assign lane_off = req_q.addr[2:0];
    assign wb_cyc   = (state == DRAIN_BUS);
    assign wb_stb   = (state == DRAIN_BUS);
    assign wb_we    = 1'b1;  // write-only master
    assign wb_adr   = {req_q.addr[31:3], 3'b000};
    assign wb_dat_w = req_q.data << {lane_off, 3'b000};
    assign wb_sel   = size_mask << lane_off;

    // classic cycle holds until the slave acks
    a_hold_until_ack: assert property (
        @(posedge clk) disable iff (!rst_n)
        (wb_stb && !wb_ack) |=> (wb_stb && $stable(wb_adr) && $stable(wb_sel)
                                  && $stable(wb_dat_w))
    );

endmodule

// File: rtl/store_queue.sv
`timescale 1ns/1ps

module store_queue import wb_pkg::*; #(
    parameter int QUEUE_DEPTH = 2
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       push,
    input  store_req_t push_req,
    input  logic       pop,
    output store_req_t head,
    output logic       full,
    output logic       empty
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    store_req_t       mem [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;

    assign full  = (count == (PTR_W + 1)'(QUEUE_DEPTH));
    assign empty = (count == '0);
    assign head  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_req;
        end
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_overflow: assert property (
        @(posedge clk) disable iff (!rst_n) push |-> !full
    );

    a_no_underflow: assert property (
        @(posedge clk) disable iff (!rst_n) pop |-> !empty
    );

endmodule

// File: rtl/arch_regfile.sv
`timescale 1ns/1ps

module arch_regfile import wb_pkg::*; (
    input  logic                         clk,
    input  logic                         rst_n,
    input  reg_write_t [NUM_SLOTS-1:0]   gpr_wr,
    input  reg_write_t [NUM_SLOTS-1:0]   seg_wr,
    input  reg_idx_t                     rd_idx,
    output gpr_data_t                    gpr_rd_data,
    output seg_data_t                    seg_rd_data
);

    localparam int NUM_REGS = 1 << $bits(reg_idx_t);

    gpr_data_t gpr_q [NUM_REGS];
    seg_data_t seg_q [NUM_REGS];

    // later slots overwrite earlier ones on the same index
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                gpr_q[r] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_SLOTS; i++) begin
                if (gpr_wr[i].en) begin
                    gpr_q[gpr_wr[i].idx] <= gpr_wr[i].data;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                seg_q[r] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_SLOTS; i++) begin
                if (seg_wr[i].en) begin
                    seg_q[seg_wr[i].idx] <= seg_wr[i].data[15:0];  // selectors are 16 bit
                end
            end
        end
    end

    assign gpr_rd_data = gpr_q[rd_idx];
    assign seg_rd_data = seg_q[rd_idx];

endmodule

// File: rtl/writeback_stage.sv
`timescale 1ns/1ps

module writeback_stage import wb_pkg::*; (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         valid_in,
    input  wb_instr_t                    instr,
    input  logic                         queue_full,
    output logic                         stall,
    output reg_write_t [NUM_SLOTS-1:0]   gpr_wr,
    output reg_write_t [NUM_SLOTS-1:0]   seg_wr,
    output logic                         push,
    output store_req_t                   push_req,
    output addr_t                        new_eip,
    output logic                         is_resteer
);

    logic [NUM_SLOTS-1:0] mem_hit;
    logic                 any_mem;
    logic                 accept;
    slot_idx_t            mem_sel;
    op_size_t             st_size;
    addr_t                target_eip;

    always_comb begin
        for (int i = 0; i < NUM_SLOTS; i++) begin
            mem_hit[i] = instr.slot[i].is_mem & instr.slot[i].wb_en;
        end
    end

    assign any_mem = |mem_hit;
    assign stall   = valid_in & any_mem & queue_full;  // only stores wait on the queue
    assign accept  = valid_in & ~stall;

    // register and segment loads, one per slot
    always_comb begin
        for (int i = 0; i < NUM_SLOTS; i++) begin
            gpr_wr[i].en   = accept & instr.slot[i].is_reg & instr.slot[i].wb_en;
            gpr_wr[i].idx  = instr.slot[i].dest[2:0];
            gpr_wr[i].data = instr.slot[i].data[31:0];
            seg_wr[i].en   = accept & instr.slot[i].is_seg & instr.slot[i].wb_en;
            seg_wr[i].idx  = instr.slot[i].dest[2:0];
            seg_wr[i].data = instr.slot[i].data[31:0];
        end
    end

    // lowest memory slot wins
    always_comb begin
        mem_sel = '0;
        for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
            if (mem_hit[i]) begin
                mem_sel = slot_idx_t'(i);
            end
        end
    end

    always_comb begin
        st_size = instr.op_size;
        for (int b = 0; b < $bits(size_ovr_t); b++) begin
            if (instr.size_ovr[b]) begin
                st_size = op_size_t'(b);
            end
        end
        if (instr.ld_eip_cs) begin
            st_size = SIZE_QWORD;  // eip and cs pushed together
        end
    end

    assign push          = accept & any_mem;
    assign push_req.addr = instr.slot[mem_sel].dest;
    assign push_req.data = instr.slot[mem_sel].data;
    assign push_req.size = st_size;

    assign target_eip = instr.ld_eip_cs ? instr.slot[0].data[31:0] : instr.br_fip;
    assign new_eip    = instr.br_taken ? target_eip : instr.eip;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            is_resteer <= 1'b0;
        end else begin
            is_resteer <= accept & instr.br_valid & ~instr.br_correct;  // mispredict
        end
    end

    // upstream never sends two stores in one instruction
    a_one_mem_slot: assert property (
        @(posedge clk) disable iff (!rst_n)
        valid_in |-> $onehot0(mem_hit)
    );

    // split stores across a qword are not handled by the drain
    a_no_qword_cross: assert property (
        @(posedge clk) disable iff (!rst_n)
        push |-> (4'(push_req.addr[2:0]) + (4'd1 << push_req.size)) <= 4'd8
    );

endmodule

// File: rtl/wb_pkg.sv
package wb_pkg;

    localparam int NUM_SLOTS = 4;  // result slots per retiring instruction

    typedef logic [63:0] wb_data_t;
    typedef logic [31:0] addr_t;
    typedef logic [2:0]  reg_idx_t;
    typedef logic [1:0]  op_size_t;   // 0 byte, 1 word, 2 dword, 3 qword
    typedef logic [3:0]  size_ovr_t;  // one-hot, zero means use op_size
    typedef logic [31:0] gpr_data_t;
    typedef logic [15:0] seg_data_t;
    typedef logic [$clog2(NUM_SLOTS)-1:0] slot_idx_t;

    localparam op_size_t SIZE_QWORD = 2'd3;

    typedef struct packed {
        wb_data_t data;
        addr_t    dest;
        logic     is_reg;
        logic     is_seg;
        logic     is_mem;
        logic     wb_en;
    } wb_slot_t;

    typedef struct packed {
        wb_slot_t [NUM_SLOTS-1:0] slot;
        op_size_t                 op_size;
        size_ovr_t                size_ovr;
        addr_t                    eip;        // fall-through
        logic                     ld_eip_cs;  // far jump, target in slot 0
        logic                     br_valid;
        logic                     br_taken;
        logic                     br_correct;
        addr_t                    br_fip;
    } wb_instr_t;

    typedef struct packed {
        addr_t    addr;
        wb_data_t data;
        op_size_t size;
    } store_req_t;

    typedef struct packed {
        logic      en;
        reg_idx_t  idx;
        gpr_data_t data;
    } reg_write_t;

    typedef enum logic {
        DRAIN_IDLE,
        DRAIN_BUS
    } drain_state_t;

endpackage
